// ==== sources.f ====
+incdir+design
design/cpu_pkg.sv
design/instruction_fetch.sv
design/cycle_controller.sv
design/register_file.sv
design/execute_unit.sv
design/memory_writeback.sv
design/cpu_top.sv
verif/cpu_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module cpu_tb

sim:
	verilator --binary --timing -f sources.f --top-module cpu_tb -o cpu_tb_sim
	@out="$$(./obj_dir/cpu_tb_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

	localparam int clock_period = 100;
	localparam int drive_delay = 10;
	localparam int reset_cycles = 5;
	localparam int num_rows = 25;
	localparam int idle_cycles = 10;
	localparam int watchdog_cycles =
		reset_cycles + num_rows + 2 + num_rows * 5 + idle_cycles + 20;

	logic clock;
	logic reset;
	logic run;
	logic load_enable;
	cpu_pkg::imem_addr_t load_address;
	cpu_pkg::word_t load_word;
	logic retire_valid;
	cpu_pkg::retire_t retire;

	cpu_pkg::word_t program_words [num_rows];
	cpu_pkg::retire_t expected [num_rows];
	string row_names [num_rows];
	int retire_cycles [num_rows];
	int row_count = 0;
	int cycle_count = 0;
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int run_edge = 0;

	cpu_top dut0 (
		.clock(clock),
		.reset(reset),
		.run(run),
		.load_enable(load_enable),
		.load_address(load_address),
		.load_word(load_word),
		.retire_valid(retire_valid),
		.retire(retire)
	);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	// edge count, read at falling edges
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		#(watchdog_cycles * clock_period);
		$display("timeout: the core did not retire the whole program in time");
		$display("Simulation failed");
		$finish;
	end

	function automatic cpu_pkg::word_t encode_register_op(input logic [4:0] sub, input int rd,
		input int ra, input int rb);
		cpu_pkg::word_t word;
		word = '0;
		word[30:25] = cpu_pkg::op_ty_base;
		word[24:20] = 5'(rd);
		word[19:15] = 5'(ra);
		word[14:10] = 5'(rb);
		word[4:0] = sub;
		return word;
	endfunction

	function automatic cpu_pkg::word_t encode_immediate_op(input cpu_pkg::opcode_t op, input int rd,
		input int ra, input logic [14:0] imm);
		cpu_pkg::word_t word;
		word = '0;
		word[30:25] = op;
		word[24:20] = 5'(rd);
		word[19:15] = 5'(ra);
		word[14:0] = imm;
		return word;
	endfunction

	function automatic cpu_pkg::word_t encode_raw(input logic [5:0] op, input int rd,
		input logic [19:0] low);
		cpu_pkg::word_t word;
		word = '0;
		word[30:25] = op;
		word[24:20] = 5'(rd);
		word[19:0] = low;
		return word;
	endfunction

	function automatic cpu_pkg::word_t encode_scaled_access(input cpu_pkg::ls_op_t sub, input int rd,
		input int ra, input int rb, input int shift);
		cpu_pkg::word_t word;
		word = '0;
		word[30:25] = cpu_pkg::op_ty_ls;
		word[24:20] = 5'(rd);
		word[19:15] = 5'(ra);
		word[14:10] = 5'(rb);
		word[9:8] = 2'(shift);
		word[7:0] = sub;
		return word;
	endfunction

	task automatic add_row(input string name, input cpu_pkg::word_t word,
		input cpu_pkg::retire_t want);
		if (row_count < num_rows) begin
			row_names[row_count] = name;
			program_words[row_count] = word;
			expected[row_count] = want;
		end
		row_count++;
	endtask

	task automatic expect_write(input string name, input cpu_pkg::word_t word, input int rd,
		input cpu_pkg::word_t value);
		cpu_pkg::retire_t want;
		want = '0;
		want.reg_write = 1'b1;
		want.write_address = 5'(rd);
		want.write_data = value;
		add_row(name, word, want);
	endtask

	task automatic expect_store(input string name, input cpu_pkg::word_t word, input int address,
		input cpu_pkg::word_t value);
		cpu_pkg::retire_t want;
		want = '0;
		want.mem_write = 1'b1;
		want.mem_address = 6'(address);
		want.mem_data = value;
		add_row(name, word, want);
	endtask

	task automatic expect_none(input string name, input cpu_pkg::word_t word);
		add_row(name, word, '0);
	endtask

	// expected values worked out by hand, all registers and memory start at zero
	task automatic build_table();
		expect_write("movi negative", encode_raw(cpu_pkg::op_movi, 1, 20'hffffb), 1, 32'hffff_fffb);
		expect_write("movi positive", encode_raw(cpu_pkg::op_movi, 2, 20'h12345), 2, 32'h0001_2345);
		expect_write("addi minus one", encode_immediate_op(cpu_pkg::op_addi, 3, 2, 15'h7fff), 3,
			32'h0001_2344);
		expect_write("addi sign bit", encode_immediate_op(cpu_pkg::op_addi, 4, 0, 15'h4000), 4,
			32'hffff_c000);
		expect_write("ori", encode_immediate_op(cpu_pkg::op_ori, 5, 0, 15'h7abc), 5, 32'h0000_7abc);
		expect_write("xori", encode_immediate_op(cpu_pkg::op_xori, 6, 1, 15'h4321), 6, 32'hffff_bcda);
		expect_write("add", encode_register_op(cpu_pkg::base_add, 7, 2, 5), 7, 32'h0001_9e01);
		expect_write("sub", encode_register_op(cpu_pkg::base_sub, 8, 5, 2), 8, 32'hffff_5777);
		expect_write("and", encode_register_op(cpu_pkg::base_and, 9, 1, 2), 9, 32'h0001_2341);
		expect_write("or", encode_register_op(cpu_pkg::base_or, 10, 4, 5), 10, 32'hffff_fabc);
		expect_write("xor", encode_register_op(cpu_pkg::base_xor, 11, 2, 3), 11, 32'h0000_0001);
		expect_write("srli", encode_register_op(cpu_pkg::base_srli, 12, 1, 4), 12, 32'h0fff_ffff);
		expect_write("slli", encode_register_op(cpu_pkg::base_slli, 13, 2, 8), 13, 32'h0123_4500);
		expect_write("rotri 4", encode_register_op(cpu_pkg::base_rotri, 14, 2, 4), 14,
			32'h5000_1234);
		expect_write("rotri 31", encode_register_op(cpu_pkg::base_rotri, 15, 1, 31), 15,
			32'hffff_fff7);
		expect_store("swi", encode_immediate_op(cpu_pkg::op_swi, 7, 0, 15'd3), 3, 32'h0001_9e01);
		expect_write("addi base", encode_immediate_op(cpu_pkg::op_addi, 16, 0, 15'd8), 16, 32'd8);
		expect_write("movi index", encode_raw(cpu_pkg::op_movi, 17, 20'd2), 17, 32'd2);
		// 8 + (2 << 2) is word 16
		expect_store("sw scaled", encode_scaled_access(cpu_pkg::ls_sw, 8, 16, 17, 2), 16,
			32'hffff_5777);
		expect_write("lwi", encode_immediate_op(cpu_pkg::op_lwi, 18, 16, 15'h7ffb), 18,
			32'h0001_9e01);
		expect_write("lw scaled", encode_scaled_access(cpu_pkg::ls_lw, 19, 16, 17, 2), 19,
			32'hffff_5777);
		expect_none("undefined opcode", encode_raw(6'b111111, 20, 20'habcde));
		expect_none("undefined base sub-op", encode_register_op(5'b11111, 20, 1, 2));
		expect_write("add loaded words", encode_register_op(cpu_pkg::base_add, 21, 19, 18), 21,
			32'h0000_f578);
		// r20 must still be zero
		expect_write("add untouched r20", encode_register_op(cpu_pkg::base_add, 22, 20, 0), 22,
			32'd0);
	endtask

	task automatic check_field(input string name, input logic [31:0] actual,
		input logic [31:0] expected_value);
		assert (actual === expected_value) else begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected_value);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: failed, %0d errors", name, error_count - errors_before);
			tests_failed++;
		end
	endtask

	task automatic check_idle_cycle();
		@(negedge clock);
		check_field("retire_valid", 32'(retire_valid), 32'd0);
	endtask

	task automatic wait_for_retire();
		do begin
			@(negedge clock);
		end while (!retire_valid);
	endtask

	task automatic compare_retire(input int index);
		cpu_pkg::retire_t want;
		want = expected[index];
		check_field("retire.reg_write", 32'(retire.reg_write), 32'(want.reg_write));
		if (want.reg_write) begin
			check_field("retire.write_address", 32'(retire.write_address), 32'(want.write_address));
			check_field("retire.write_data", retire.write_data, want.write_data);
		end
		check_field("retire.mem_write", 32'(retire.mem_write), 32'(want.mem_write));
		if (want.mem_write) begin
			check_field("retire.mem_address", 32'(retire.mem_address), 32'(want.mem_address));
			check_field("retire.mem_data", retire.mem_data, want.mem_data);
		end
	endtask

	initial begin
		int errors_before;
		reset = 1'b1;
		run = 1'b0;
		load_enable = 1'b0;
		load_address = '0;
		load_word = '0;
		build_table();
		assert (row_count == num_rows) else begin
			$display("the program table holds %0d rows instead of %0d", row_count, num_rows);
			error_count++;
		end

		errors_before = error_count;
		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge clock);
			if (i == reset_cycles - 1) begin
				#(drive_delay);
				reset = 1'b0;
			end
			check_idle_cycle();
		end
		for (int i = 0; i < num_rows; i++) begin
			@(posedge clock);
			#(drive_delay);
			load_enable = 1'b1;
			load_address = cpu_pkg::imem_addr_t'(i);
			load_word = program_words[i];
			check_idle_cycle();
		end
		@(posedge clock);
		#(drive_delay);
		load_enable = 1'b0;
		check_idle_cycle();
		report_test("reset and program load with run low", errors_before);

		// run is sampled at the next edge
		@(posedge clock);
		#(drive_delay);
		run = 1'b1;
		run_edge = cycle_count + 1;
		for (int i = 0; i < num_rows; i++) begin
			errors_before = error_count;
			wait_for_retire();
			retire_cycles[i] = cycle_count;
			compare_retire(i);
			report_test($sformatf("row %0d %s", i, row_names[i]), errors_before);
			// last instruction is fetched at the coming edge
			if (i == num_rows - 2) begin
				@(posedge clock);
				#(drive_delay);
				run = 1'b0;
			end
		end

		errors_before = error_count;
		check_field("first retire cycle", 32'(retire_cycles[0]), 32'(run_edge + 4));
		for (int i = 1; i < num_rows; i++) begin
			check_field("retire spacing", 32'(retire_cycles[i] - retire_cycles[i - 1]), 32'd5);
		end
		report_test("retire timing", errors_before);

		errors_before = error_count;
		for (int i = 0; i < idle_cycles; i++) begin
			check_idle_cycle();
		end
		report_test("core holds after run low", errors_before);

		$display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
			error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input wire logic clock,
	input wire logic reset,
	input wire logic run,
	input wire logic load_enable,
	input wire cpu_pkg::imem_addr_t load_address,
	input wire cpu_pkg::word_t load_word,
	output logic retire_valid,
	output cpu_pkg::retire_t retire
);

	cpu_pkg::word_t instruction;
	cpu_pkg::control_t control;
	logic fetch_enable;
	logic latch_enable;
	logic execute_enable;
	logic memory_enable;
	logic writeback_enable;
	cpu_pkg::word_t read_data_a;
	cpu_pkg::word_t read_data_b;
	cpu_pkg::reg_addr_t read_address_b;
	cpu_pkg::word_t result;
	logic write_enable;
	cpu_pkg::reg_addr_t write_address;
	cpu_pkg::word_t write_data;

	// stores read rt on port b once the address is computed
	assign read_address_b = (memory_enable && control.mem_write) ?
		instruction[24:20] : instruction[14:10];

	instruction_fetch fetch0 (
		.clock(clock),
		.reset(reset),
		.fetch_enable(fetch_enable),
		.latch_enable(latch_enable),
		.load_enable(load_enable),
		.load_address(load_address),
		.load_word(load_word),
		.instruction(instruction)
	);

	cycle_controller controller0 (
		.clock(clock),
		.reset(reset),
		.run(run),
		.instruction(instruction),
		.fetch_enable(fetch_enable),
		.latch_enable(latch_enable),
		.execute_enable(execute_enable),
		.memory_enable(memory_enable),
		.writeback_enable(writeback_enable),
		.control(control)
	);

	register_file regs0 (
		.clock(clock),
		.reset(reset),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.read_address_a(instruction[19:15]),
		.read_address_b(read_address_b),
		.read_data_a(read_data_a),
		.read_data_b(read_data_b)
	);

	execute_unit execute0 (
		.clock(clock),
		.reset(reset),
		.execute_enable(execute_enable),
		.instruction(instruction),
		.control(control),
		.read_data_a(read_data_a),
		.read_data_b(read_data_b),
		.result(result)
	);

	memory_writeback memwb0 (
		.clock(clock),
		.reset(reset),
		.memory_enable(memory_enable),
		.writeback_enable(writeback_enable),
		.instruction(instruction),
		.control(control),
		.result(result),
		.store_data(read_data_b),
		.write_enable(write_enable),
		.write_address(write_address),
		.write_data(write_data),
		.retire_valid(retire_valid),
		.retire(retire)
	);

endmodule

`default_nettype wire

// ==== design/memory_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module memory_writeback (
	input wire logic clock,
	input wire logic reset,
	input wire logic memory_enable,
	input wire logic writeback_enable,
	input wire cpu_pkg::word_t instruction,
	input wire cpu_pkg::control_t control,
	input wire cpu_pkg::word_t result,
	input wire cpu_pkg::word_t store_data,
	output logic write_enable,
	output cpu_pkg::reg_addr_t write_address,
	output cpu_pkg::word_t write_data,
	output logic retire_valid,
	output cpu_pkg::retire_t retire
);

	cpu_pkg::word_t dmem [0:(1 << `CPU_DMEM_ADDR_WIDTH)-1];
	cpu_pkg::dmem_addr_t mem_address;
	cpu_pkg::word_t load_data;
	cpu_pkg::word_t stored_word;
	cpu_pkg::retire_t record;

	// upper address bits ignored
	assign mem_address = result[`CPU_DMEM_ADDR_WIDTH-1:0];

	always_ff @(posedge clock) begin
		if (memory_enable && control.mem_write) begin
			dmem[mem_address] <= store_data;
		end
		if (memory_enable && control.mem_read) begin
			load_data <= dmem[mem_address];
		end
		// port b moves back to rb after memory, keep the store value for retire
		if (memory_enable) begin
			stored_word <= store_data;
		end
	end

	always_comb begin
		case (control.wb_sel)
			cpu_pkg::wb_imm20:
				write_data = {{(`CPU_DATA_WIDTH-20){instruction[19]}}, instruction[19:0]};
			cpu_pkg::wb_mem: write_data = load_data;
			default: write_data = result;
		endcase
	end

	assign write_enable = writeback_enable && control.reg_write;
	assign write_address = instruction[24:20];

	always_comb begin
		record.reg_write = control.reg_write;
		record.write_address = write_address;
		record.write_data = control.reg_write ? write_data : '0;
		record.mem_write = control.mem_write;
		record.mem_address = (control.mem_read || control.mem_write) ? mem_address : '0;
		record.mem_data = control.mem_write ? stored_word : '0;
	end

	// report goes out the cycle after writeback
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= writeback_enable;
		end
	end

	always_ff @(posedge clock) begin
		if (writeback_enable) begin
			retire <= record;
		end
	end

endmodule

`default_nettype wire

// ==== design/execute_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module execute_unit (
	input wire logic clock,
	input wire logic reset,
	input wire logic execute_enable,
	input wire cpu_pkg::word_t instruction,
	input wire cpu_pkg::control_t control,
	input wire cpu_pkg::word_t read_data_a,
	input wire cpu_pkg::word_t read_data_b,
	output cpu_pkg::word_t result
);

	cpu_pkg::word_t operand_b;
	cpu_pkg::word_t alu_out;
	cpu_pkg::word_t scaled_address;
	cpu_pkg::word_t next_result;
	logic [4:0] shift_amount;
	logic [2*`CPU_DATA_WIDTH-1:0] rotate_wide;

	always_comb begin
		case (control.operand_sel)
			cpu_pkg::opnd_imm5: operand_b = cpu_pkg::word_t'(instruction[14:10]);
			cpu_pkg::opnd_imm15s:
				operand_b = {{(`CPU_DATA_WIDTH-15){instruction[14]}}, instruction[14:0]};
			cpu_pkg::opnd_imm15u: operand_b = cpu_pkg::word_t'(instruction[14:0]);
			default: operand_b = read_data_b;
		endcase
	end

	assign shift_amount = operand_b[4:0];
	// rotate by shifting a doubled copy
	assign rotate_wide = {read_data_a, read_data_a} >> shift_amount;

	always_comb begin
		case (control.alu_op)
			cpu_pkg::alu_add: alu_out = read_data_a + operand_b;
			cpu_pkg::alu_sub: alu_out = read_data_a - operand_b;
			cpu_pkg::alu_and: alu_out = read_data_a & operand_b;
			cpu_pkg::alu_or: alu_out = read_data_a | operand_b;
			cpu_pkg::alu_xor: alu_out = read_data_a ^ operand_b;
			cpu_pkg::alu_srl: alu_out = read_data_a >> shift_amount;
			cpu_pkg::alu_sll: alu_out = read_data_a << shift_amount;
			cpu_pkg::alu_rotr: alu_out = rotate_wide[`CPU_DATA_WIDTH-1:0];
			default: alu_out = operand_b;
		endcase
	end

	// lw/sw address, base plus rb scaled by bits 9:8
	assign scaled_address = read_data_a + (read_data_b << instruction[9:8]);
	assign next_result = control.address_scaled ? scaled_address : alu_out;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			result <= '0;
		end else if (execute_enable) begin
			result <= next_result;
		end
	end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module register_file (
	input wire logic clock,
	input wire logic reset,
	input wire logic write_enable,
	input wire cpu_pkg::reg_addr_t write_address,
	input wire cpu_pkg::word_t write_data,
	input wire cpu_pkg::reg_addr_t read_address_a,
	input wire cpu_pkg::reg_addr_t read_address_b,
	output cpu_pkg::word_t read_data_a,
	output cpu_pkg::word_t read_data_b
);

	localparam int reg_count = 1 << `CPU_REG_ADDR_WIDTH;

	cpu_pkg::word_t regs [0:reg_count-1];

	// r0 is writable like any other register
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable) begin
			regs[write_address] <= write_data;
		end
	end

	assign read_data_a = regs[read_address_a];
	assign read_data_b = regs[read_address_b];

endmodule

`default_nettype wire

// ==== design/cycle_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module cycle_controller (
	input wire logic clock,
	input wire logic reset,
	input wire logic run,
	input wire cpu_pkg::word_t instruction,
	output logic fetch_enable,
	output logic latch_enable,
	output logic execute_enable,
	output logic memory_enable,
	output logic writeback_enable,
	output cpu_pkg::control_t control
);

	cpu_pkg::cpu_state_t state;
	cpu_pkg::cpu_state_t next_state;
	cpu_pkg::opcode_t opcode;
	cpu_pkg::base_op_t base_op;
	cpu_pkg::ls_op_t ls_op;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= cpu_pkg::state_fetch;
		end else begin
			state <= next_state;
		end
	end

	// run only matters in fetch, an instruction in flight always completes
	always_comb begin
		case (state)
			cpu_pkg::state_fetch:
				next_state = run ? cpu_pkg::state_latch : cpu_pkg::state_fetch;
			cpu_pkg::state_latch: next_state = cpu_pkg::state_execute;
			cpu_pkg::state_execute: next_state = cpu_pkg::state_memory;
			cpu_pkg::state_memory: next_state = cpu_pkg::state_writeback;
			default: next_state = cpu_pkg::state_fetch;
		endcase
	end

	assign fetch_enable = (state == cpu_pkg::state_fetch) && run;
	assign latch_enable = (state == cpu_pkg::state_latch);
	assign execute_enable = (state == cpu_pkg::state_execute);
	assign memory_enable = (state == cpu_pkg::state_memory);
	assign writeback_enable = (state == cpu_pkg::state_writeback);

	assign opcode = cpu_pkg::opcode_t'(instruction[30:25]);
	assign base_op = cpu_pkg::base_op_t'(instruction[4:0]);
	assign ls_op = cpu_pkg::ls_op_t'(instruction[7:0]);

	// decoder, anything unknown falls through as a no-op
	always_comb begin
		control.alu_op = cpu_pkg::alu_pass;
		control.operand_sel = cpu_pkg::opnd_reg;
		control.address_scaled = 1'b0;
		control.wb_sel = cpu_pkg::wb_alu;
		control.reg_write = 1'b0;
		control.mem_read = 1'b0;
		control.mem_write = 1'b0;
		case (opcode)
			cpu_pkg::op_ty_base: begin
				control.reg_write = 1'b1;
				case (base_op)
					cpu_pkg::base_add: control.alu_op = cpu_pkg::alu_add;
					cpu_pkg::base_sub: control.alu_op = cpu_pkg::alu_sub;
					cpu_pkg::base_and: control.alu_op = cpu_pkg::alu_and;
					cpu_pkg::base_xor: control.alu_op = cpu_pkg::alu_xor;
					cpu_pkg::base_or: control.alu_op = cpu_pkg::alu_or;
					cpu_pkg::base_slli: begin
						control.alu_op = cpu_pkg::alu_sll;
						control.operand_sel = cpu_pkg::opnd_imm5;
					end
					cpu_pkg::base_srli: begin
						control.alu_op = cpu_pkg::alu_srl;
						control.operand_sel = cpu_pkg::opnd_imm5;
					end
					cpu_pkg::base_rotri: begin
						control.alu_op = cpu_pkg::alu_rotr;
						control.operand_sel = cpu_pkg::opnd_imm5;
					end
					default: control.reg_write = 1'b0;
				endcase
			end
			cpu_pkg::op_addi: begin
				control.alu_op = cpu_pkg::alu_add;
				control.operand_sel = cpu_pkg::opnd_imm15s;
				control.reg_write = 1'b1;
			end
			cpu_pkg::op_ori: begin
				control.alu_op = cpu_pkg::alu_or;
				control.operand_sel = cpu_pkg::opnd_imm15u;
				control.reg_write = 1'b1;
			end
			cpu_pkg::op_xori: begin
				control.alu_op = cpu_pkg::alu_xor;
				control.operand_sel = cpu_pkg::opnd_imm15u;
				control.reg_write = 1'b1;
			end
			cpu_pkg::op_movi: begin
				control.wb_sel = cpu_pkg::wb_imm20;
				control.reg_write = 1'b1;
			end
			cpu_pkg::op_lwi, cpu_pkg::op_swi: begin
				// base plus signed offset through the adder
				control.alu_op = cpu_pkg::alu_add;
				control.operand_sel = cpu_pkg::opnd_imm15s;
				control.wb_sel = cpu_pkg::wb_mem;
				control.reg_write = (opcode == cpu_pkg::op_lwi);
				control.mem_read = (opcode == cpu_pkg::op_lwi);
				control.mem_write = (opcode == cpu_pkg::op_swi);
			end
			cpu_pkg::op_ty_ls: begin
				control.address_scaled = 1'b1;
				control.wb_sel = cpu_pkg::wb_mem;
				control.reg_write = (ls_op == cpu_pkg::ls_lw);
				control.mem_read = (ls_op == cpu_pkg::ls_lw);
				control.mem_write = (ls_op == cpu_pkg::ls_sw);
			end
			default: begin
				control.reg_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/instruction_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module instruction_fetch (
	input wire logic clock,
	input wire logic reset,
	input wire logic fetch_enable,
	input wire logic latch_enable,
	input wire logic load_enable,
	input wire cpu_pkg::imem_addr_t load_address,
	input wire cpu_pkg::word_t load_word,
	output cpu_pkg::word_t instruction
);

	cpu_pkg::word_t imem [0:(1 << `CPU_IMEM_ADDR_WIDTH)-1];
	cpu_pkg::imem_addr_t pc;
	cpu_pkg::word_t fetch_word;

	// program load, only used while the core is stopped
	always_ff @(posedge clock) begin
		if (load_enable) begin
			imem[load_address] <= load_word;
		end
	end

	// no branches, so the counter only ever increments
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (fetch_enable) begin
			pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_enable) begin
			fetch_word <= imem[pc];
		end
	end

	// instruction register
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instruction <= '0;
		end else if (latch_enable) begin
			instruction <= fetch_word;
		end
	end

endmodule

`default_nettype wire

// ==== design/cpu_pkg.sv ====
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_WIDTH-1:0] word_t;
	typedef logic [`CPU_REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [`CPU_IMEM_ADDR_WIDTH-1:0] imem_addr_t;
	typedef logic [`CPU_DMEM_ADDR_WIDTH-1:0] dmem_addr_t;

	// instruction bits 30:25
	typedef enum logic [5:0] {
		op_ty_base = 6'b100000,
		op_addi    = 6'b101000,
		op_ori     = 6'b101100,
		op_xori    = 6'b101011,
		op_movi    = 6'b100010,
		op_lwi     = 6'b000010,
		op_swi     = 6'b001010,
		op_ty_ls   = 6'b011100
	} opcode_t;

	// instruction bits 4:0 under op_ty_base
	typedef enum logic [4:0] {
		base_add   = 5'b00000,
		base_sub   = 5'b00001,
		base_and   = 5'b00010,
		base_xor   = 5'b00011,
		base_or    = 5'b00100,
		base_slli  = 5'b01000,
		base_srli  = 5'b01001,
		base_rotri = 5'b01011
	} base_op_t;

	// instruction bits 7:0 under op_ty_ls
	typedef enum logic [7:0] {
		ls_lw = 8'b00000010,
		ls_sw = 8'b00001010
	} ls_op_t;

	typedef enum logic [2:0] {
		state_fetch,
		state_latch,
		state_execute,
		state_memory,
		state_writeback
	} cpu_state_t;

	typedef enum logic [1:0] {
		opnd_reg,
		opnd_imm5,
		opnd_imm15s,
		opnd_imm15u
	} operand_sel_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_srl,
		alu_sll,
		alu_rotr,
		alu_pass
	} alu_op_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_imm20,
		wb_mem
	} wb_sel_t;

	typedef struct packed {
		alu_op_t alu_op;
		operand_sel_t operand_sel;
		logic address_scaled;
		wb_sel_t wb_sel;
		logic reg_write;
		logic mem_read;
		logic mem_write;
	} control_t;

	typedef struct packed {
		logic reg_write;
		reg_addr_t write_address;
		word_t write_data;
		logic mem_write;
		dmem_addr_t mem_address;
		word_t mem_data;
	} retire_t;

endpackage

`default_nettype wire

// ==== design/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// register and memory word width
`define CPU_DATA_WIDTH 32

// 32 general registers
`define CPU_REG_ADDR_WIDTH 5

// 64-word instruction memory
`define CPU_IMEM_ADDR_WIDTH 6

// 64-word data memory, word indexed
`define CPU_DMEM_ADDR_WIDTH 6

`endif
